// File: common/des_pipe_pkg.sv
`default_nettype none

// Basic DES datapath types and round constants
// Bits use the 1-to-N numbering of the DES standard (bit 1 is the MSB)
package des_pipe_pkg;

    typedef logic [1:64] des_block_t;   // Plaintext or ciphertext block
    typedef logic [1:32] des_half_t;    // Left or right Feistel half
    typedef logic [1:48] des_subkey_t;  // Round key out of PC-2
    typedef logic [1:64] des_key_t;     // Full key, parity bits still in place

    localparam int DES_ROUNDS = 16;

    // Left rotation of C and D before each round
    localparam int des_shift_sched [DES_ROUNDS] = '{
        1, 1, 2, 2, 2, 2, 2, 2,
        1, 2, 2, 2, 2, 2, 2, 1
    };

endpackage : des_pipe_pkg

`default_nettype wire

// File: common/des_tables_pkg.sv
`default_nettype none

// Standard DES tables plus helper functions that apply them
// Every table entry names the source bit, counted from 1 at the MSB
package des_tables_pkg;

    import des_pipe_pkg::*;

    localparam int des_ip_tab [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    // Inverse of the initial permutation
    localparam int des_fp_tab [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam int des_e_tab [48] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    localparam int des_p_tab [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    // Drops the parity bits, yields C (1..28) then D (29..56)
    localparam int des_pc1_tab [56] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    localparam int des_pc2_tab [48] = '{
        14, 17, 11, 24,  1,  5,
         3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8,
        16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    // Each box is laid out row by row, index = {b1, b6, b2..b5}
    localparam logic [3:0] des_sbox_tab [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

    function automatic des_block_t des_ip(des_block_t b);
        des_block_t o;
        for (int i = 0; i < 64; i++) o[i+1] = b[des_ip_tab[i]];
        return o;
    endfunction

    function automatic des_block_t des_fp(des_block_t b);
        des_block_t o;
        for (int i = 0; i < 64; i++) o[i+1] = b[des_fp_tab[i]];
        return o;
    endfunction

    // 32 -> 48, edge bits of each nibble are shared with the neighbours
    function automatic logic [1:48] des_expand(des_half_t r);
        logic [1:48] o;
        for (int i = 0; i < 48; i++) o[i+1] = r[des_e_tab[i]];
        return o;
    endfunction

    // Eight 6-in / 4-out lookups
    function automatic des_half_t des_sbox(logic [1:48] x);
        des_half_t   o;
        logic [1:6]  chunk;
        for (int s = 0; s < 8; s++) begin
            chunk = x[s*6+1 +: 6];
            o[s*4+1 +: 4] = des_sbox_tab[s][{chunk[1], chunk[6], chunk[2:5]}];  // Row, column
        end
        return o;
    endfunction

    function automatic des_half_t des_pbox(des_half_t x);
        des_half_t o;
        for (int i = 0; i < 32; i++) o[i+1] = x[des_p_tab[i]];
        return o;
    endfunction

    function automatic logic [1:56] des_pc1(des_key_t k);
        logic [1:56] o;
        for (int i = 0; i < 56; i++) o[i+1] = k[des_pc1_tab[i]];
        return o;
    endfunction

    // Picks 48 of the 56 rotated C/D bits
    function automatic des_subkey_t des_pc2(logic [1:56] cd);
        des_subkey_t o;
        for (int i = 0; i < 48; i++) o[i+1] = cd[des_pc2_tab[i]];
        return o;
    endfunction

endpackage : des_tables_pkg

`default_nettype wire

// File: des/des_round.sv
`timescale 1ns/1ps
`default_nettype none

// One Feistel round with a register in the middle of the f function
// Expansion, key mix and S-boxes sit before the register, P-box and left XOR after it
module des_round
    import des_pipe_pkg::*, des_tables_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              in_valid,     // Block present at the round input
    input  des_half_t              l_in,
    input  des_half_t              r_in,
    input  des_subkey_t            subkey,       // Already chosen for this block's mode
    input  wire logic              in_decrypt,
    input  wire logic [TAG_W-1:0]  in_tag,
    output logic                   out_valid,
    output des_half_t              l_out,
    output des_half_t              r_out,
    output logic                   out_decrypt,
    output logic [TAG_W-1:0]       out_tag
);

    logic [1:48] e_mix;       // E(R) xor K
    des_half_t   s_val;       // Raw S-box result
    des_half_t   s_reg;       // S-box result held for the P-box
    des_half_t   l_reg;
    des_half_t   r_reg;

    assign e_mix = des_expand(r_in) ^ subkey;
    assign s_val = des_sbox(e_mix);

    // Only the valid flag needs a known state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;  // One stage of delay
        end
    end

    // Payload is captured only for a live block
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s_reg       <= s_val;
            l_reg       <= l_in;
            r_reg       <= r_in;
            out_decrypt <= in_decrypt;  // Mode rides with its block
            out_tag     <= in_tag;
        end
    end

    assign l_out = r_reg;                    // L(i) = R(i-1)
    assign r_out = l_reg ^ des_pbox(s_reg);  // R(i) = L(i-1) xor f

endmodule : des_round

`default_nettype wire

// File: des/des_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

// Unrolled key schedule, all sixteen subkeys out of the held key at once
// Pure logic, no clock. The key only changes while the pipeline is idle
module des_key_schedule
    import des_pipe_pkg::*, des_tables_pkg::*;
(
    input  des_key_t    key,
    output des_subkey_t subkeys [DES_ROUNDS]   // Index 0 is round 1
);

    logic [1:56] cd0;   // PC-1 output

    assign cd0 = des_pc1(key);

    always_comb begin
        logic [1:28] c;
        logic [1:28] d;
        c = cd0[1:28];   // C half
        d = cd0[29:56];  // D half
        for (int r = 0; r < DES_ROUNDS; r++) begin
            // Rotations accumulate from round to round
            if (des_shift_sched[r] == 1) begin
                c = {c[2:28], c[1]};
                d = {d[2:28], d[1]};
            end else begin
                c = {c[3:28], c[1:2]};   // Double shift
                d = {d[3:28], d[1:2]};
            end
            subkeys[r] = des_pc2({c, d});
        end
    end

endmodule : des_key_schedule

`default_nettype wire

// File: des/des_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

// Sixteen-stage DES datapath
// A new block may enter each cycle, fixed latency of DES_ROUNDS cycles
module des_pipeline
    import des_pipe_pkg::*, des_tables_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              din_valid,
    input  des_block_t             din,
    input  wire logic              din_decrypt,   // 1 = run the schedule backwards
    input  wire logic [TAG_W-1:0]  din_tag,
    input  des_subkey_t            subkeys [DES_ROUNDS],
    output logic                   dout_valid,
    output des_block_t             dout,
    output logic                   dout_decrypt,
    output logic [TAG_W-1:0]       dout_tag
);

    // Stage 0 is the IP output, stage k the output of round k
    logic             v_s   [DES_ROUNDS+1];
    des_half_t        l_s   [DES_ROUNDS+1];
    des_half_t        r_s   [DES_ROUNDS+1];
    logic             dec_s [DES_ROUNDS+1];
    logic [TAG_W-1:0] tag_s [DES_ROUNDS+1];
    des_subkey_t      rk    [DES_ROUNDS];     // Subkey seen by each round
    des_block_t       ip_blk;

    assign ip_blk   = des_ip(din);
    assign v_s[0]   = din_valid;
    assign l_s[0]   = ip_blk[1:32];
    assign r_s[0]   = ip_blk[33:64];
    assign dec_s[0] = din_decrypt;
    assign tag_s[0] = din_tag;

    for (genvar i = 0; i < DES_ROUNDS; i++) begin : g_round
        // Decryption uses K16 first, each stage looks at its own block's mode
        assign rk[i] = dec_s[i] ? subkeys[DES_ROUNDS-1-i] : subkeys[i];

        des_round #(
            .TAG_W (TAG_W)
        ) u_round (
            .clk         (clk),
            .arst_n      (arst_n),
            .in_valid    (v_s[i]),
            .l_in        (l_s[i]),
            .r_in        (r_s[i]),
            .subkey      (rk[i]),
            .in_decrypt  (dec_s[i]),
            .in_tag      (tag_s[i]),
            .out_valid   (v_s[i+1]),
            .l_out       (l_s[i+1]),
            .r_out       (r_s[i+1]),
            .out_decrypt (dec_s[i+1]),
            .out_tag     (tag_s[i+1])
        );
    end

    // Last round is not swapped, so R16 goes first into FP
    assign dout         = des_fp({r_s[DES_ROUNDS], l_s[DES_ROUNDS]});
    assign dout_valid   = v_s[DES_ROUNDS];
    assign dout_decrypt = dec_s[DES_ROUNDS];
    assign dout_tag     = tag_s[DES_ROUNDS];

endmodule : des_pipeline

`default_nettype wire

// File: verilog/des_key_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Key holding register beside the datapath
// key_valid tells whether any key was loaded since reset
module des_key_reg
    import des_pipe_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic key_load,   // One-cycle load strobe
    input  des_key_t  key,
    output des_key_t  key_q,      // Feeds the key schedule
    output logic      key_valid
);

    // Zero key until the first load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_q <= '0;
        end else if (key_load) begin
            key_q <= key;
        end
    end

    // Sticky once set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_valid <= 1'b0;
        end else if (key_load) begin
            key_valid <= 1'b1;   // Stays up until the next reset
        end
    end

endmodule : des_key_reg

`default_nettype wire

// File: verilog/des_top.sv
`timescale 1ns/1ps
`default_nettype none

// DES engine top, key register and schedule steering the round pipeline
module des_top
    import des_pipe_pkg::*;
#(
    parameter int TAG_W = 4   // Caller tag width
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              key_load,
    input  des_key_t               key,
    input  wire logic              din_valid,
    input  des_block_t             din,
    input  wire logic              din_decrypt,
    input  wire logic [TAG_W-1:0]  din_tag,
    output logic                   dout_valid,
    output des_block_t             dout,
    output logic                   dout_decrypt,
    output logic [TAG_W-1:0]       dout_tag,
    output logic                   key_valid
);

    des_key_t    key_q;                  // Held key
    des_subkey_t subkeys [DES_ROUNDS];   // K1..K16

    des_key_reg u_key_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_load  (key_load),
        .key       (key),
        .key_q     (key_q),
        .key_valid (key_valid)
    );

    des_key_schedule u_key_schedule (
        .key     (key_q),
        .subkeys (subkeys)
    );

    des_pipeline #(
        .TAG_W (TAG_W)
    ) u_pipeline (
        .clk          (clk),
        .arst_n       (arst_n),
        .din_valid    (din_valid),
        .din          (din),
        .din_decrypt  (din_decrypt),
        .din_tag      (din_tag),
        .subkeys      (subkeys),
        .dout_valid   (dout_valid),
        .dout         (dout),
        .dout_decrypt (dout_decrypt),
        .dout_tag     (dout_tag)
    );

endmodule : des_top

`default_nettype wire

// File: test/des_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Timing checks on the DES round pipeline
// Bound into des_pipeline so the DUT sources stay untouched
module des_chk #(
    parameter int DEPTH = 16   // Rounds between din and dout
) (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic din_valid,
    input wire logic dout_valid
);

    logic [DEPTH-1:0] v_hist;   // Past din_valid values, bit 0 newest

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_hist <= '0;
        end else begin
            v_hist <= {v_hist[DEPTH-2:0], din_valid};
        end
    end

    // Output strobe is the input strobe DEPTH edges later
    a_fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
        dout_valid == v_hist[DEPTH-1])
        else $error("dout_valid does not follow din_valid by %0d cycles", DEPTH);

    // Nothing leaves the pipeline during reset
    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !dout_valid)
        else $error("dout_valid high while reset is asserted");

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(dout_valid))
        else $error("dout_valid is unknown out of reset");

endmodule : des_chk

bind des_pipeline des_chk u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .din_valid  (din_valid),
    .dout_valid (dout_valid)
);

`default_nettype wire

// File: test/des_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the pipelined DES engine
// Reference model uses [N-1:0] vectors, table entry n maps to bit N-n
module des_tb
    import des_tables_pkg::*;
();

    localparam int TAG_W   = 4;
    localparam int LATENCY = 16;    // One register per round

    logic             clk;
    logic             arst_n;
    logic             key_load;
    logic [63:0]      key;
    logic             din_valid;
    logic [63:0]      din;
    logic             din_decrypt;
    logic [TAG_W-1:0] din_tag;
    logic             dout_valid;
    logic [63:0]      dout;
    logic             dout_decrypt;
    logic [TAG_W-1:0] dout_tag;
    logic             key_valid;

    // Scoreboard, one entry per block in flight
    logic [63:0]      exp_data [$];
    logic             exp_dec  [$];
    logic [TAG_W-1:0] exp_tag  [$];
    int               exp_cyc  [$];   // Cycle count when din_valid was driven

    int               cyc;
    logic [63:0]      cur_key;        // Key the DUT should be holding
    logic [63:0]      last_dout;      // Latest ciphertext, for the round trip
    logic [63:0]      e_data;
    logic             e_dec;
    logic [TAG_W-1:0] e_tag;
    int               e_cyc;

    des_top #(
        .TAG_W (TAG_W)
    ) DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .key_load     (key_load),
        .key          (key),
        .din_valid    (din_valid),
        .din          (din),
        .din_decrypt  (din_decrypt),
        .din_tag      (din_tag),
        .dout_valid   (dout_valid),
        .dout         (dout),
        .dout_decrypt (dout_decrypt),
        .dout_tag     (dout_tag),
        .key_valid    (key_valid)
    );

    always #5 clk = ~clk;              // 10 ns period

    always @(posedge clk) cyc <= cyc + 1;

    // Plain DES, subkeys first, then sixteen Feistel rounds
    function automatic logic [63:0] des_ref(input logic [63:0] k, input logic [63:0] blk,
                                            input logic dec);
        logic [55:0] cd;
        logic [27:0] c;
        logic [27:0] d;
        logic [47:0] ks [16];
        logic [63:0] p;
        logic [63:0] o;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] f;
        logic [31:0] t;
        logic [47:0] x;
        logic [5:0]  six;
        int          sh;
        for (int i = 0; i < 56; i++) cd[55-i] = k[64-des_pc1_tab[i]];
        c = cd[55:28];
        d = cd[27:0];
        for (int rnd = 0; rnd < 16; rnd++) begin
            sh = (rnd == 0 || rnd == 1 || rnd == 8 || rnd == 15) ? 1 : 2;  // Single shifts
            for (int j = 0; j < sh; j++) begin
                c = {c[26:0], c[27]};
                d = {d[26:0], d[27]};
            end
            cd = {c, d};
            for (int i = 0; i < 48; i++) ks[rnd][47-i] = cd[56-des_pc2_tab[i]];
        end
        for (int i = 0; i < 64; i++) p[63-i] = blk[64-des_ip_tab[i]];
        l = p[63:32];
        r = p[31:0];
        for (int rnd = 0; rnd < 16; rnd++) begin
            for (int i = 0; i < 48; i++) x[47-i] = r[32-des_e_tab[i]];
            x = x ^ ks[dec ? 15 - rnd : rnd];   // Reverse key order to decrypt
            for (int sb = 0; sb < 8; sb++) begin
                six = x[47-6*sb -: 6];
                s[31-4*sb -: 4] = des_sbox_tab[sb][{six[5], six[0], six[4:1]}];
            end
            for (int i = 0; i < 32; i++) f[31-i] = s[32-des_p_tab[i]];
            t = r;
            r = l ^ f;
            l = t;
        end
        p = {r, l};                         // No swap after round 16
        for (int i = 0; i < 64; i++) o[63-i] = p[64-des_fp_tab[i]];
        return o;
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
        $display("FAIL time=%0t %s got %h expected %h", $time, sig, got, exp);
        stop_run();
    endtask

    task automatic fail_msg(input string why);
        $display("ERROR time=%0t %s", $time, why);
        stop_run();
    endtask

    // Key goes in with a one-cycle strobe, key_q follows one edge later
    task automatic load_key(input logic [63:0] k);
        @(negedge clk);
        key_load = 1'b1;
        key      = k;
        @(negedge clk);
        key_load = 1'b0;
        cur_key  = k;
        assert (key_valid === 1'b1) else fail_value("key_valid", key_valid, 1);
    endtask

    // Leaves din_valid high so calls can run back to back
    task automatic send_block(input logic [63:0] blk, input logic dec,
                              input logic [TAG_W-1:0] tag, input logic [63:0] exp);
        @(negedge clk);
        din_valid   = 1'b1;
        din         = blk;
        din_decrypt = dec;
        din_tag     = tag;
        exp_data.push_back(exp);
        exp_dec.push_back(dec);
        exp_tag.push_back(tag);
        exp_cyc.push_back(cyc);
    endtask

    task automatic go_idle();
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < 4 * LATENCY + 100) begin
            @(negedge clk);
            n++;
        end
        assert (exp_data.size() == 0)
            else fail_msg("timeout waiting for the pipeline to drain");
    endtask

    task automatic send_one(input logic [63:0] blk, input logic dec);
        send_block(blk, dec, $urandom_range(0, (1 << TAG_W) - 1), des_ref(cur_key, blk, dec));
        go_idle();
        drain();
    endtask

    // Scoreboard check, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n && dout_valid) begin
            assert (exp_data.size() != 0)
                else fail_msg("dout_valid with no block outstanding");
            e_data    = exp_data.pop_front();
            e_dec     = exp_dec.pop_front();
            e_tag     = exp_tag.pop_front();
            e_cyc     = exp_cyc.pop_front();
            last_dout = dout;
            assert (cyc == e_cyc + LATENCY)
                else fail_value("dout_valid latency", cyc - e_cyc, LATENCY);
            assert (dout === e_data) else fail_value("dout", dout, e_data);
            assert (dout_decrypt === e_dec) else fail_value("dout_decrypt", dout_decrypt, e_dec);
            assert (dout_tag === e_tag) else fail_value("dout_tag", dout_tag, e_tag);
        end
    end

    initial begin : stimulus
        logic [63:0] blk;
        logic        dec;
        void'($urandom(32'h2605236e));   // Single seed for the run
        clk         = 1'b0;
        arst_n      = 1'b0;
        key_load    = 1'b0;
        key         = '0;
        din_valid   = 1'b0;
        din         = '0;
        din_decrypt = 1'b0;
        din_tag     = '0;
        cyc         = 0;
        cur_key     = '0;
        last_dout   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Reset state
        @(negedge clk);
        assert (dout_valid === 1'b0) else fail_value("dout_valid", dout_valid, 0);
        assert (key_valid === 1'b0) else fail_value("key_valid", key_valid, 0);

        // Known answer from the standard worked example
        load_key(64'h133457799BBCDFF1);
        assert (des_ref(cur_key, 64'h0123456789ABCDEF, 1'b0) === 64'h85E813540F0AB405)
            else fail_msg("reference model disagrees with the known answer");
        send_block(64'h0123456789ABCDEF, 1'b0, 4'h5, 64'h85E813540F0AB405);
        go_idle();
        drain();

        // Single blocks, fresh key each time, both modes
        for (int i = 0; i < 20; i++) begin
            load_key({$urandom, $urandom});
            send_one({$urandom, $urandom}, i[0]);
        end

        // Full rate, one block per cycle
        for (int i = 0; i < 100; i++) begin
            blk = {$urandom, $urandom};
            dec = $urandom_range(0, 1);
            send_block(blk, dec, $urandom_range(0, (1 << TAG_W) - 1),
                       des_ref(cur_key, blk, dec));
        end
        go_idle();
        drain();

        // Round trip through the DUT's own ciphertext
        for (int i = 0; i < 5; i++) begin
            blk = {$urandom, $urandom};
            send_one(blk, 1'b0);
            send_block(last_dout, 1'b1, $urandom_range(0, (1 << TAG_W) - 1), blk);
            go_idle();
            drain();
        end

        // New key once the pipeline is empty
        load_key({$urandom, $urandom});
        for (int i = 0; i < 12; i++) begin
            blk = {$urandom, $urandom};
            dec = $urandom_range(0, 1);
            send_block(blk, dec, i[TAG_W-1:0], des_ref(cur_key, blk, dec));
        end
        go_idle();
        drain();

        repeat (LATENCY + 2) @(negedge clk);   // Catch stray output strobes
        $display("Test OK");
        $finish;
    end

endmodule : des_tb

`default_nettype wire

// File: files.f
common/des_pipe_pkg.sv
common/des_tables_pkg.sv
des/des_round.sv
des/des_key_schedule.sv
des/des_pipeline.sv
verilog/des_key_reg.sv
verilog/des_top.sv
test/des_chk.sv
test/des_tb.sv
